// ==== rtl/cv_ctrl_cfg.svh ====
// Constants of the console controller front end
// Include wherever scan codes, keypad line codes or widths are needed

`ifndef CV_CTRL_CFG_SVH
`define CV_CTRL_CFG_SVH

//////////////////////////////
// Sizes
//////////////////////////////
`define CV_PORTS        2
`define CV_KEYPAD_BITS  20
`define CV_DIGITS       10
// Keys 0 to 9, star, number, purple, blue
`define CV_PRIO_KEYS    14
`define CV_LINE_BITS    4
`define CV_SCAN_BITS    8

//////////////////////////////
// PS/2 set 2 scan codes
//////////////////////////////
// Main row digits
`define CV_SC_MAIN_0    8'h45
`define CV_SC_MAIN_1    8'h16
`define CV_SC_MAIN_2    8'h1E
`define CV_SC_MAIN_3    8'h26
`define CV_SC_MAIN_4    8'h25
`define CV_SC_MAIN_5    8'h2E
`define CV_SC_MAIN_6    8'h36
`define CV_SC_MAIN_7    8'h3D
`define CV_SC_MAIN_8    8'h3E
`define CV_SC_MAIN_9    8'h46

// Numeric pad
`define CV_SC_PAD_0     8'h70
`define CV_SC_PAD_1     8'h69
`define CV_SC_PAD_2     8'h72
`define CV_SC_PAD_3     8'h7A
`define CV_SC_PAD_4     8'h6B
`define CV_SC_PAD_5     8'h73
`define CV_SC_PAD_6     8'h74
`define CV_SC_PAD_7     8'h6C
`define CV_SC_PAD_8     8'h75
`define CV_SC_PAD_9     8'h7D
`define CV_SC_PAD_STAR  8'h7C
`define CV_SC_PAD_MINUS 8'h7B
`define CV_SC_LSHIFT    8'h12
`define CV_SC_RSHIFT    8'h59

//////////////////////////////
// Console keypad line codes
//////////////////////////////
`define CV_KEY_0        4'b0011
`define CV_KEY_1        4'b1110
`define CV_KEY_2        4'b1101
`define CV_KEY_3        4'b0110
`define CV_KEY_4        4'b0001
`define CV_KEY_5        4'b1001
`define CV_KEY_6        4'b0111
`define CV_KEY_7        4'b1100
`define CV_KEY_8        4'b1000
`define CV_KEY_9        4'b1011
`define CV_KEY_STAR     4'b1010
`define CV_KEY_NUMBER   4'b0101
`define CV_KEY_PURPLE   4'b0100
`define CV_KEY_BLUE     4'b0010
`define CV_KEY_NONE     4'b1111

`endif

// ==== rtl/cv_ctrl_pkg.sv ====
// Types shared by the controller front end modules and the testbench
// Referenced by scoped name, sizes come from the config header

`include "cv_ctrl_cfg.svh"

package cv_ctrl_pkg;

	//////////////////////////////
	// Host side
	//////////////////////////////

	// Host joystick word, all bits active high, blue in bit 19
	typedef struct packed {
		logic                     blue;
		logic                     purple;
		logic [`CV_DIGITS-1:0]    key;
		logic                     number;
		logic                     star;
		logic                     fire2;
		logic                     fire1;
		logic                     up;
		logic                     down;
		logic                     left;
		logic                     right;
	} joy_state_t;

	// Keyboard event, new event on every change of toggle
	typedef struct packed {
		logic                     toggle;
		logic                     pressed;
		logic                     extended;
		logic [`CV_SCAN_BITS-1:0] code;
	} ps2_event_t;

	// Keys held on the keyboard that stand in for keypad buttons
	typedef struct packed {
		logic                     minus;
		logic                     shift;
		logic                     star;
		logic [`CV_DIGITS-1:0]    digit;
	} kbd_buttons_t;

	// Keypad sources of one port, declared in priority order
	typedef struct packed {
		logic [`CV_DIGITS-1:0]    key;
		logic                     star;
		logic                     number;
		logic                     purple;
		logic                     blue;
		logic                     up;
		logic                     down;
		logic                     left;
		logic                     right;
		logic                     fire1;
		logic                     fire2;
	} keypad_vec_t;

	//////////////////////////////
	// Console side
	//////////////////////////////

	// Both select lines active low
	typedef struct packed {
		logic                     key_n;
		logic                     joy_n;
	} cv_select_t;

	typedef struct packed {
		logic                     up_n;
		logic                     down_n;
		logic                     left_n;
		logic                     right_n;
	} cv_dir_t;

	// The same four lines carry a keypad code or the directions
	typedef union packed {
		logic [`CV_LINE_BITS-1:0] code;
		cv_dir_t                  dir;
	} cv_lines_u;

	typedef struct packed {
		cv_lines_u                lines;
		logic                     fire_n;
	} cv_port_t;

endpackage

// ==== rtl/ps2_keypad_decode.sv ====
// Keyboard side of the controller front end
// Watches the toggle strobe of the PS/2 event word and keeps the emulated keypad buttons

`include "cv_ctrl_cfg.svh"

module ps2_keypad_decode (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  cv_ctrl_pkg::ps2_event_t   kbd_i,
	output cv_ctrl_pkg::kbd_buttons_t buttons_o
);

	logic                      toggle_q;
	logic                      event_seen;
	cv_ctrl_pkg::kbd_buttons_t buttons_q;

	// A change of the toggle bit marks a new event
	assign event_seen = kbd_i.toggle != toggle_q;

	//////////////////////////////
	// Button state
	//////////////////////////////

	// Only the low code byte is matched, so extended keys alias to plain ones
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q  <= 1'b0;
			buttons_q <= '0;
		end else begin
			toggle_q <= kbd_i.toggle;
			if (event_seen) begin
				case (kbd_i.code)
					`CV_SC_MAIN_0, `CV_SC_PAD_0: begin
						buttons_q.digit[0] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_1, `CV_SC_PAD_1: begin
						buttons_q.digit[1] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_2, `CV_SC_PAD_2: begin
						buttons_q.digit[2] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_3, `CV_SC_PAD_3: begin
						buttons_q.digit[3] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_4, `CV_SC_PAD_4: begin
						buttons_q.digit[4] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_5, `CV_SC_PAD_5: begin
						buttons_q.digit[5] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_6, `CV_SC_PAD_6: begin
						buttons_q.digit[6] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_7, `CV_SC_PAD_7: begin
						buttons_q.digit[7] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_8, `CV_SC_PAD_8: begin
						buttons_q.digit[8] <= kbd_i.pressed;
					end
					`CV_SC_MAIN_9, `CV_SC_PAD_9: begin
						buttons_q.digit[9] <= kbd_i.pressed;
					end
					`CV_SC_PAD_STAR: begin
						buttons_q.star <= kbd_i.pressed;
					end
					// Either shift key drives the one shift button
					`CV_SC_LSHIFT, `CV_SC_RSHIFT: begin
						buttons_q.shift <= kbd_i.pressed;
					end
					`CV_SC_PAD_MINUS: begin
						buttons_q.minus <= kbd_i.pressed;
					end
					default: begin
						// Keys without a keypad role are dropped
						buttons_q <= buttons_q;
					end
				endcase
			end
		end
	end

	assign buttons_o = buttons_q;

	// Buttons hold still unless the previous edge saw a new event
	a_buttons_follow_event: assert property (
		@(posedge clk_sys) disable iff (reset)
		!event_seen |=> $stable(buttons_q)
	) else $error("keypad buttons changed without a keyboard event");

endmodule

// ==== rtl/keypad_merge.sv ====
// Joins the host joysticks and the keyboard buttons into one keypad vector per port
// Port A is index 0, port B index 1; the keyboard feeds both ports

`include "cv_ctrl_cfg.svh"

module keypad_merge (
	input  cv_ctrl_pkg::joy_state_t   joy_a_i,
	input  cv_ctrl_pkg::joy_state_t   joy_b_i,
	input  logic                      swap_i,
	input  cv_ctrl_pkg::kbd_buttons_t buttons_i,
	output cv_ctrl_pkg::keypad_vec_t  keypad_o [`CV_PORTS]
);

	cv_ctrl_pkg::joy_state_t   joy_sel [`CV_PORTS];
	cv_ctrl_pkg::keypad_vec_t  kbd_vec;
	logic [`CV_KEYPAD_BITS-1:0] kbd_bits;

	// Host word reordered into keypad priority order
	function automatic cv_ctrl_pkg::keypad_vec_t remap(input cv_ctrl_pkg::joy_state_t joy);
		cv_ctrl_pkg::keypad_vec_t kp;
		kp.key    = joy.key;
		kp.star   = joy.star;
		kp.number = joy.number;
		kp.purple = joy.purple;
		kp.blue   = joy.blue;
		kp.up     = joy.up;
		kp.down   = joy.down;
		kp.left   = joy.left;
		kp.right  = joy.right;
		kp.fire1  = joy.fire1;
		kp.fire2  = joy.fire2;
		return kp;
	endfunction

	//////////////////////////////
	// Joystick swap
	//////////////////////////////
	assign joy_sel[0] = swap_i ? joy_b_i : joy_a_i;
	assign joy_sel[1] = swap_i ? joy_a_i : joy_b_i;

	//////////////////////////////
	// Keyboard contribution
	//////////////////////////////

	// Shift+8 and shift+3 give star and number as on a US layout
	always_comb begin
		kbd_vec        = '0;
		kbd_vec.key    = buttons_i.digit;
		kbd_vec.star   = buttons_i.star | (buttons_i.shift & buttons_i.digit[8]);
		kbd_vec.number = buttons_i.minus | (buttons_i.shift & buttons_i.digit[3]);
	end

	assign kbd_bits = kbd_vec;

	for (genvar p = 0; p < `CV_PORTS; p++) begin : g_port
		assign keypad_o[p] = cv_ctrl_pkg::keypad_vec_t'(remap(joy_sel[p]) | kbd_bits);
	end

endmodule

// ==== rtl/cv_port_encoder.sv ====
// Drives the four data lines and the fire line of one console controller port
// Keypad and joystick terms are each forced high while their select is high

`include "cv_ctrl_cfg.svh"

module cv_port_encoder (
	input  cv_ctrl_pkg::keypad_vec_t keypad_i,
	input  cv_ctrl_pkg::cv_select_t  sel_i,
	output cv_ctrl_pkg::cv_port_t    port_o
);

	// Line code per priority index, key 0 first and blue last
	localparam logic [`CV_LINE_BITS-1:0] KEY_CODES [`CV_PRIO_KEYS] = '{
		`CV_KEY_0,
		`CV_KEY_1,
		`CV_KEY_2,
		`CV_KEY_3,
		`CV_KEY_4,
		`CV_KEY_5,
		`CV_KEY_6,
		`CV_KEY_7,
		`CV_KEY_8,
		`CV_KEY_9,
		`CV_KEY_STAR,
		`CV_KEY_NUMBER,
		`CV_KEY_PURPLE,
		`CV_KEY_BLUE
	};

	logic [`CV_PRIO_KEYS-1:0] prio;
	cv_ctrl_pkg::cv_lines_u   key_lines;
	cv_ctrl_pkg::cv_lines_u   joy_lines;
	logic                     key_fire_n;
	logic                     joy_fire_n;

	// Index 0 is key 0, index 13 is blue
	assign prio = {keypad_i.blue, keypad_i.purple, keypad_i.number, keypad_i.star, keypad_i.key};

	//////////////////////////////
	// Keypad term
	//////////////////////////////

	// Scan down so the lowest index that is set wins
	always_comb begin
		key_lines.code = `CV_KEY_NONE;
		key_fire_n     = 1'b1;
		if (!sel_i.key_n) begin
			for (int i = `CV_PRIO_KEYS - 1; i >= 0; i--) begin
				if (prio[i]) begin
					key_lines.code = KEY_CODES[i];
				end
			end
			// Fire 2 shows up on the fire line in keypad mode
			key_fire_n = ~keypad_i.fire2;
		end
	end

	//////////////////////////////
	// Joystick term
	//////////////////////////////
	always_comb begin
		joy_lines.code = '1;
		joy_fire_n     = 1'b1;
		if (!sel_i.joy_n) begin
			joy_lines.dir.up_n    = ~keypad_i.up;
			joy_lines.dir.down_n  = ~keypad_i.down;
			joy_lines.dir.left_n  = ~keypad_i.left;
			joy_lines.dir.right_n = ~keypad_i.right;
			joy_fire_n            = ~keypad_i.fire1;
		end
	end

	// Open-collector style wired AND of both modes
	assign port_o.lines.code = key_lines.code & joy_lines.code;
	assign port_o.fire_n     = key_fire_n & joy_fire_n;

	// Idle port must read all ones to the console
	always_comb begin
		if (sel_i.key_n && sel_i.joy_n) begin
			a_idle_port_high: assert final (port_o == '1)
			else $error("port lines not all high with both selects inactive");
		end
	end

endmodule

// ==== rtl/cv_ctrl_top.sv ====
// Controller front end of the console core
// Host joysticks and keyboard events in, two console controller ports out

`include "cv_ctrl_cfg.svh"

module cv_ctrl_top (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  cv_ctrl_pkg::joy_state_t  joy_a_i,
	input  cv_ctrl_pkg::joy_state_t  joy_b_i,
	input  logic                     swap_i,
	input  cv_ctrl_pkg::ps2_event_t  kbd_i,
	input  cv_ctrl_pkg::cv_select_t  sel_i [`CV_PORTS],
	output cv_ctrl_pkg::cv_port_t    port_o [`CV_PORTS]
);

	cv_ctrl_pkg::kbd_buttons_t buttons;
	cv_ctrl_pkg::keypad_vec_t  keypad [`CV_PORTS];

	//////////////////////////////
	// Keyboard decode
	//////////////////////////////

	// The only clocked stage, one edge from toggle to buttons
	ps2_keypad_decode i_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd_i     (kbd_i),
		.buttons_o (buttons)
	);

	//////////////////////////////
	// Keypad merge
	//////////////////////////////
	keypad_merge i_merge (
		.joy_a_i   (joy_a_i),
		.joy_b_i   (joy_b_i),
		.swap_i    (swap_i),
		.buttons_i (buttons),
		.keypad_o  (keypad)
	);

	//////////////////////////////
	// Port encoders
	//////////////////////////////
	cv_port_encoder i_port_a (
		.keypad_i  (keypad[0]),
		.sel_i     (sel_i[0]),
		.port_o    (port_o[0])
	);

	cv_port_encoder i_port_b (
		.keypad_i  (keypad[1]),
		.sel_i     (sel_i[1]),
		.port_o    (port_o[1])
	);

endmodule

// ==== tb/cv_ctrl_model.svh ====
// Reference model of the controller front end, included inside the testbench module
// Uses rng_state and abort_run of the including module

`ifndef CV_CTRL_MODEL_SVH
`define CV_CTRL_MODEL_SVH

localparam logic [7:0] MAIN_CODES [`CV_DIGITS] = '{`CV_SC_MAIN_0, `CV_SC_MAIN_1,
	`CV_SC_MAIN_2, `CV_SC_MAIN_3, `CV_SC_MAIN_4, `CV_SC_MAIN_5, `CV_SC_MAIN_6,
	`CV_SC_MAIN_7, `CV_SC_MAIN_8, `CV_SC_MAIN_9};
localparam logic [7:0] PAD_CODES [`CV_DIGITS] = '{`CV_SC_PAD_0, `CV_SC_PAD_1,
	`CV_SC_PAD_2, `CV_SC_PAD_3, `CV_SC_PAD_4, `CV_SC_PAD_5, `CV_SC_PAD_6,
	`CV_SC_PAD_7, `CV_SC_PAD_8, `CV_SC_PAD_9};
// Keys 0 to 9, star, number, purple, blue
localparam logic [3:0] KEY_LINES [`CV_PRIO_KEYS] = '{`CV_KEY_0, `CV_KEY_1, `CV_KEY_2,
	`CV_KEY_3, `CV_KEY_4, `CV_KEY_5, `CV_KEY_6, `CV_KEY_7, `CV_KEY_8, `CV_KEY_9,
	`CV_KEY_STAR, `CV_KEY_NUMBER, `CV_KEY_PURPLE, `CV_KEY_BLUE};

function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// One keyboard event applied to the button model, extended flag ignored
function automatic cv_ctrl_pkg::kbd_buttons_t apply_event(
	input cv_ctrl_pkg::kbd_buttons_t btn,
	input cv_ctrl_pkg::ps2_event_t   ev
);
	cv_ctrl_pkg::kbd_buttons_t nxt;
	nxt = btn;
	for (int d = 0; d < `CV_DIGITS; d++) begin
		if (ev.code == MAIN_CODES[d] || ev.code == PAD_CODES[d]) begin
			nxt.digit[d] = ev.pressed;
		end
	end
	if (ev.code == `CV_SC_PAD_STAR) begin
		nxt.star = ev.pressed;
	end
	if (ev.code == `CV_SC_LSHIFT || ev.code == `CV_SC_RSHIFT) begin
		nxt.shift = ev.pressed;
	end
	if (ev.code == `CV_SC_PAD_MINUS) begin
		nxt.minus = ev.pressed;
	end
	return nxt;
endfunction

// Keypad sources of port idx after swap and keyboard merge, 0 is port A
function automatic cv_ctrl_pkg::keypad_vec_t expected_keypad(
	input cv_ctrl_pkg::joy_state_t   ja,
	input cv_ctrl_pkg::joy_state_t   jb,
	input logic                      swp,
	input cv_ctrl_pkg::kbd_buttons_t btn,
	input int                        idx
);
	cv_ctrl_pkg::joy_state_t  joy;
	cv_ctrl_pkg::keypad_vec_t kp;
	joy       = ((idx == 0) != swp) ? ja : jb;
	kp.key    = joy.key | btn.digit;
	kp.star   = joy.star | btn.star | (btn.shift & btn.digit[8]);
	kp.number = joy.number | btn.minus | (btn.shift & btn.digit[3]);
	kp.purple = joy.purple;
	kp.blue   = joy.blue;
	kp.up     = joy.up;
	kp.down   = joy.down;
	kp.left   = joy.left;
	kp.right  = joy.right;
	kp.fire1  = joy.fire1;
	kp.fire2  = joy.fire2;
	return kp;
endfunction

// Expected lines and fire of one port from its keypad sources
function automatic cv_ctrl_pkg::cv_port_t expected_port(
	input cv_ctrl_pkg::keypad_vec_t kp,
	input cv_ctrl_pkg::cv_select_t  s
);
	logic [13:0]           keys;
	logic [3:0]            key_code;
	logic [3:0]            dir_code;
	logic                  found;
	cv_ctrl_pkg::cv_port_t res;
	keys[9:0] = kp.key;
	keys[10]  = kp.star;
	keys[11]  = kp.number;
	keys[12]  = kp.purple;
	keys[13]  = kp.blue;
	key_code  = `CV_KEY_NONE;
	found     = 1'b0;
	for (int i = 0; i < `CV_PRIO_KEYS; i++) begin
		if (!s.key_n && !found && keys[i]) begin
			key_code = KEY_LINES[i];
			found    = 1'b1;
		end
	end
	dir_code = s.joy_n ? 4'b1111 : ~{kp.up, kp.down, kp.left, kp.right};
	res.lines.code = key_code & dir_code;
	res.fire_n     = (s.key_n | ~kp.fire2) & (s.joy_n | ~kp.fire1);
	return res;
endfunction

task automatic check_port(input cv_ctrl_pkg::cv_port_t got, input cv_ctrl_pkg::cv_port_t exp,
	input string what);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_keypad(input cv_ctrl_pkg::keypad_vec_t got,
	input cv_ctrl_pkg::keypad_vec_t exp, input string what);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_buttons(input cv_ctrl_pkg::kbd_buttons_t got,
	input cv_ctrl_pkg::kbd_buttons_t exp, input string what);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

`endif

// ==== tb/tb_cv_ctrl.sv ====
// Testbench of the controller front end
// Random joystick, swap and select stimulus plus keyboard events, checked against a model

`include "cv_ctrl_cfg.svh"

module tb_cv_ctrl;

	logic                      clk_sys;
	logic                      reset;
	cv_ctrl_pkg::joy_state_t   joy_a;
	cv_ctrl_pkg::joy_state_t   joy_b;
	logic                      swap;
	cv_ctrl_pkg::ps2_event_t   kbd;
	cv_ctrl_pkg::cv_select_t   sel [`CV_PORTS];
	cv_ctrl_pkg::cv_port_t     port [`CV_PORTS];
	logic [31:0]               rng_state;
	cv_ctrl_pkg::kbd_buttons_t btn_model;
	logic                      toggle_model;

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	`include "cv_ctrl_model.svh"

	cv_ctrl_top i_dut (
		.clk_sys (clk_sys),
		.reset   (reset),
		.joy_a_i (joy_a),
		.joy_b_i (joy_b),
		.swap_i  (swap),
		.kbd_i   (kbd),
		.sel_i   (sel),
		.port_o  (port)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#4 clk_sys = ~clk_sys;
		end
	end

	// Shift combinations hide behind their digit on the lines, so the merged keypad is seen too
	task automatic compare_all(input string when_s);
		cv_ctrl_pkg::keypad_vec_t kp;
		for (int p = 0; p < `CV_PORTS; p++) begin
			kp = expected_keypad(joy_a, joy_b, swap, btn_model, p);
			check_keypad(i_dut.keypad[p], kp, $sformatf("keypad %0d %s", p, when_s));
			check_port(port[p], expected_port(kp, sel[p]),
				$sformatf("port %0d %s", p, when_s));
		end
		check_buttons(i_dut.buttons, btn_model, $sformatf("buttons %s", when_s));
	endtask

	//////////////////////////////
	// Checking process
	//////////////////////////////
	// Model follows the decode rule at each rising edge, outputs checked mid phase
	initial begin
		btn_model    = '0;
		toggle_model = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (reset) begin
				btn_model    = '0;
				toggle_model = 1'b0;
			end else if (kbd.toggle != toggle_model) begin
				btn_model    = apply_event(btn_model, kbd);
				toggle_model = kbd.toggle;
			end
			compare_all("after rising edge");
			@(negedge clk_sys);
			#2;
			compare_all("after input change");
		end
	end

	task automatic drive_random(input int cycles, input logic [1:0] sel_bits, input logic rand_sel);
		logic [31:0] r;
		repeat (cycles) begin
			@(negedge clk_sys);
			r = next_random() & next_random();
			joy_a = r[19:0];
			r = next_random() & next_random();
			joy_b = r[19:0];
			r = next_random();
			swap = r[0];
			sel[0] = rand_sel ? r[2:1] : sel_bits;
			sel[1] = rand_sel ? r[4:3] : sel_bits;
		end
	endtask

	// New event by toggle change, then wait until the buttons take it
	task automatic send_event(input logic [7:0] code, input logic pressed);
		cv_ctrl_pkg::ps2_event_t   ev;
		cv_ctrl_pkg::kbd_buttons_t target;
		logic [31:0]               r;
		int                        waited;
		r = next_random();
		@(negedge clk_sys);
		ev.toggle   = ~kbd.toggle;
		ev.pressed  = pressed;
		ev.extended = r[0];
		ev.code     = code;
		target      = apply_event(btn_model, ev);
		kbd         = ev;
		waited      = 0;
		while (i_dut.buttons !== target) begin
			if (waited == 4) begin
				$display("Keyboard event %h was not taken within 4 clock cycles", code);
				abort_run();
			end
			@(negedge clk_sys);
			waited++;
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		logic [31:0] r;
		logic [7:0]  code;
		rng_state = 32'hbfe260c2;
		reset     = 1'b1;
		joy_a     = '0;
		joy_b     = '0;
		swap      = 1'b0;
		kbd       = '0;
		sel[0]    = '1;
		sel[1]    = '1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// Idle inputs read all ones under every select pair
		for (int s = 0; s < 4; s++) begin
			@(negedge clk_sys);
			sel[0] = s[1:0];
			sel[1] = s[1:0];
			#2;
			check_port(port[0], '1, "idle port A");
			check_port(port[1], '1, "idle port B");
		end

		drive_random(60, 2'b01, 1'b0);
		drive_random(60, 2'b10, 1'b0);
		drive_random(60, 2'b00, 1'b0);
		drive_random(60, 2'b00, 1'b1);

		// Keyboard alone on the keypad lines
		@(negedge clk_sys);
		joy_a  = '0;
		joy_b  = '0;
		sel[0] = 2'b01;
		sel[1] = 2'b01;
		for (int d = 0; d < `CV_DIGITS; d++) begin
			r = next_random();
			code = r[0] ? MAIN_CODES[d] : PAD_CODES[d];
			send_event(code, 1'b1);
			send_event(code, 1'b0);
		end
		send_event(`CV_SC_MAIN_7, 1'b1);
		send_event(`CV_SC_PAD_2, 1'b1);
		send_event(`CV_SC_MAIN_2, 1'b0);
		send_event(`CV_SC_PAD_7, 1'b0);
		send_event(`CV_SC_LSHIFT, 1'b1);
		send_event(`CV_SC_MAIN_8, 1'b1);
		send_event(`CV_SC_MAIN_8, 1'b0);
		send_event(`CV_SC_LSHIFT, 1'b0);
		send_event(`CV_SC_RSHIFT, 1'b1);
		send_event(`CV_SC_PAD_3, 1'b1);
		send_event(`CV_SC_RSHIFT, 1'b0);
		send_event(`CV_SC_PAD_3, 1'b0);
		send_event(`CV_SC_PAD_MINUS, 1'b1);
		send_event(`CV_SC_PAD_MINUS, 1'b0);
		send_event(`CV_SC_PAD_STAR, 1'b1);
		send_event(8'h1C, 1'b1);
		send_event(8'hF0, 1'b0);
		send_event(`CV_SC_PAD_STAR, 1'b0);

		// Fields move but the toggle stays
		@(negedge clk_sys);
		kbd.code    = MAIN_CODES[5];
		kbd.pressed = 1'b1;
		repeat (3) @(negedge clk_sys);

		// Mixed joystick, select and keyboard traffic
		repeat (40) begin
			drive_random(2, 2'b00, 1'b1);
			r = next_random();
			code = r[0] ? MAIN_CODES[r[11:8] % 10] : PAD_CODES[r[15:12] % 10];
			if (r[3:1] == 3'd0) begin
				code = r[31:24];
			end
			send_event(code, r[2]);
		end

		@(negedge clk_sys);
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== cv_ctrl.f ====
+incdir+rtl
+incdir+tb
rtl/cv_ctrl_pkg.sv
rtl/ps2_keypad_decode.sv
rtl/keypad_merge.sv
rtl/cv_port_encoder.sv
rtl/cv_ctrl_top.sv
tb/tb_cv_ctrl.sv
